// ==== dga_consts.svh ====
/* Constants for the decode gate array: command and select codes, panel FIFO depth
   and power timing counts. Include in any file that decodes codes or sizes the FIFO.
*/
`ifndef DGA_CONSTS_SVH
`define DGA_CONSTS_SVH

// panel fifo size in bytes
`define DGA_FIFO_DEPTH 13

// power timing, in clk cycles
`define DGA_POW_SETTLE 8
`define DGA_POW_HOLD   6

// idb source-select codes
`define DGA_IDBS_NONE  5'd0
`define DGA_IDBS_PANEL 5'd1
`define DGA_IDBS_CSR   5'd2
`define DGA_IDBS_DOUT  5'd3
`define DGA_IDBS_IOR   5'd4

// command codes, anything else decodes to nothing
`define DGA_COMM_NOP   5'd0
`define DGA_COMM_MREQ  5'd1
`define DGA_COMM_IORQ  5'd2
`define DGA_COMM_FETCH 5'd3
`define DGA_COMM_WRITE 5'd4
`define DGA_COMM_LDPAN 5'd5

`endif

// ==== dga_pkg.sv ====
/* Shared types of the decode gate array: bus widths and the power controller states.
   Imported by wildcard in every block that uses one of them.
*/
`default_nettype none

package dga_pkg;

  // ********************************************************
  // bus widths
  // ********************************************************

  // one byte of the internal data bus
  typedef logic [7:0] idb_byte_t;

  // low half of the idb, carries the panel status
  typedef logic [3:0] idb_nibble_t;

  // idb source-select code from the microcode
  typedef logic [4:0] cs_idbs_t;

  // command code from the microcode
  typedef logic [4:0] cs_comm_t;

  // ********************************************************
  // power controller
  // ********************************************************

  // off     -> sense low, clear held
  // settle  -> sense high, waiting out the settle count
  // run     -> power good, clear released
  // fail    -> sense lost, warning before clear returns
  typedef enum logic [1:0] {
    POW_OFF    = 2'd0,
    POW_SETTLE = 2'd1,
    POW_RUN    = 2'd2,
    POW_FAIL   = 2'd3
  } pow_state_e;

endpackage

`default_nettype wire

// ==== idb_bus_if.sv ====
/* IDB byte path between the power controller, the source selector and the panel
   FIFO. One instance lives in the top level; each block takes its own modport.
*/
`timescale 1ns/10ps
`default_nettype none

interface idb_bus_if import dga_pkg::*; ();

  // raw byte from the external bus pins
  idb_byte_t   idb_in;
  // power controller status nibble
  idb_nibble_t status;
  // panel status source selected, active low
  logic        epan_n;
  // byte as the fifo sees it, status merged in
  idb_byte_t   idb_merged;

  // power controller publishes the status
  modport pow (
    output status
  );

  // selector owns the panel enable and the merge
  modport sel (
    input  idb_in,
    input  status,
    output epan_n,
    output idb_merged
  );

  // fifo only captures the merged byte
  modport fifo (
    input idb_merged
  );

endinterface

`default_nettype wire

// ==== panel_fifo.sv ====
/* Circular byte FIFO feeding the panel address port. Captures the merged IDB byte
   on wr, pops on rd, and always shows the head byte on data_out.
*/
`timescale 1ns/10ps
`default_nettype none
`include "dga_consts.svh"

module panel_fifo import dga_pkg::*; #(
  parameter int DEPTH = `DGA_FIFO_DEPTH
) (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  clear,
  input  wire logic  wr,
  input  wire logic  rd,
  idb_bus_if.fifo    bus,
  output idb_byte_t  data_out,
  output logic       full,
  output logic       empty
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  idb_byte_t         mem [DEPTH];
  logic [PW-1:0]     wr_ptr;
  logic [PW-1:0]     rd_ptr;
  logic [CW-1:0]     count;
  logic              wr_ok;
  logic              rd_ok;

  // write while full is simply lost
  assign wr_ok = wr && !full;
  assign rd_ok = rd && !empty;

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);

  // show-ahead, head byte is always visible
  assign data_out = mem[rd_ptr];

  // storage, no reset needed
  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= bus.idb_merged;
    end
  end

  // pointers wrap at DEPTH, not at a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves count alone
      if (wr_ok && !rd_ok) begin
        count <= count + 1'b1;
      end else if (rd_ok && !wr_ok) begin
        count <= count - 1'b1;
      end
    end
  end

  // occupancy bound
  a_count_bound : assert property (@(posedge clk) disable iff (!rst_n)
    count <= CW'(DEPTH));

endmodule

`default_nettype wire

// ==== power_ctl.sv ====
/* Power-up and power-fail sequencer. Turns the raw power-sense level into the
   system clear, the power-fail warning and the panel status nibble.
*/
`timescale 1ns/10ps
`default_nettype none
`include "dga_consts.svh"

module power_ctl import dga_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic pow_sense,
  output logic      clear,
  output logic      pfail_n,
  idb_bus_if.pow    bus
);

  pow_state_e  state_q;
  pow_state_e  state_d;
  // shared by the settle and hold windows
  logic [3:0]  cnt_q;
  logic [3:0]  cnt_d;

  // ********************************************************
  // state register
  // ********************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= POW_OFF;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // ********************************************************
  // next state
  // ********************************************************

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      POW_OFF: begin
        cnt_d = '0;
        if (pow_sense) begin
          state_d = POW_SETTLE;
        end
      end
      POW_SETTLE: begin
        // any dropout restarts the whole power-up
        if (!pow_sense) begin
          state_d = POW_OFF;
          cnt_d   = '0;
        end else if (cnt_q == 4'(`DGA_POW_SETTLE)) begin
          state_d = POW_RUN;
          cnt_d   = '0;
        end else begin
          cnt_d = cnt_q + 4'd1;
        end
      end
      POW_RUN: begin
        cnt_d = '0;
        if (!pow_sense) begin
          state_d = POW_FAIL;
        end
      end
      POW_FAIL: begin
        // hold runs out regardless of sense
        if (cnt_q == 4'(`DGA_POW_HOLD - 1)) begin
          state_d = POW_OFF;
          cnt_d   = '0;
        end else begin
          cnt_d = cnt_q + 4'd1;
        end
      end
      default: begin
        state_d = POW_OFF;
        cnt_d   = '0;
      end
    endcase
  end

  // ********************************************************
  // outputs decoded from the state
  // ********************************************************

  // clear stays low through the fail warning
  assign clear   = (state_q == POW_OFF) || (state_q == POW_SETTLE);
  assign pfail_n = (state_q != POW_FAIL);

  // bit 3 reads zero on the panel
  assign bus.status = {1'b0, clear, (state_q == POW_FAIL), (state_q == POW_RUN)};

  // power good never drops straight back into clear
  a_no_clear_after_good : assert property (@(posedge clk) disable iff (!rst_n)
    $past(bus.status[0]) |-> !clear);

endmodule

`default_nettype wire

// ==== idb_select.sv ====
/* IDB source selector. Registers the source-select code, decodes it to active-low
   bus enables and merges the power status onto the IDB low nibble for the panel code.
*/
`timescale 1ns/10ps
`default_nettype none
`include "dga_consts.svh"

module idb_select import dga_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     clear,
  input  wire cs_idbs_t cs_idbs,
  output logic          ecsr_n,
  output logic          edo_n,
  output logic          eior_n,
  idb_bus_if.sel        bus
);

  cs_idbs_t code_q;
  // active-high selects, one per source
  logic     sel_pan;
  logic     sel_csr;
  logic     sel_do;
  logic     sel_ior;

  // code sampled once per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      code_q <= `DGA_IDBS_NONE;
    end else begin
      code_q <= cs_idbs;
    end
  end

  // ********************************************************
  // decode
  // ********************************************************

  always_comb begin
    sel_pan = 1'b0;
    sel_csr = 1'b0;
    sel_do  = 1'b0;
    sel_ior = 1'b0;
    // nothing drives the idb while the system is cleared
    if (!clear) begin
      case (code_q)
        `DGA_IDBS_PANEL: sel_pan = 1'b1;
        `DGA_IDBS_CSR:   sel_csr = 1'b1;
        `DGA_IDBS_DOUT:  sel_do  = 1'b1;
        `DGA_IDBS_IOR:   sel_ior = 1'b1;
        default: ;
      endcase
    end
  end

  assign bus.epan_n = !sel_pan;
  assign ecsr_n     = !sel_csr;
  assign edo_n      = !sel_do;
  assign eior_n     = !sel_ior;

  // status replaces the low nibble, high nibble always from the pins
  assign bus.idb_merged = {bus.idb_in[7:4], bus.epan_n ? bus.idb_in[3:0] : bus.status};

  // only one source may own the bus
  a_one_enable : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({!bus.epan_n, !ecsr_n, !edo_n, !eior_n}));

endmodule

`default_nettype wire

// ==== comm_decode.sv ====
/* Command decoder. Registers the command code into one-cycle memory, IO, fetch,
   write and panel-load strobes, all held idle while clear is active.
*/
`timescale 1ns/10ps
`default_nettype none
`include "dga_consts.svh"

module comm_decode import dga_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     clear,
  input  wire cs_comm_t cs_comm,
  output logic          mreq_n,
  output logic          iorq_n,
  output logic          fetch,
  output logic          write,
  output logic          ldpan
);

  // strobe vector bit positions
  localparam int S_MREQ  = 0;
  localparam int S_IORQ  = 1;
  localparam int S_FETCH = 2;
  localparam int S_WRITE = 3;
  localparam int S_LDPAN = 4;

  // all active high inside the block
  logic [4:0] strb_d;
  logic [4:0] strb_q;
  logic [4:0] strb;

  // ********************************************************
  // code decode
  // ********************************************************

  always_comb begin
    strb_d = '0;
    case (cs_comm)
      `DGA_COMM_NOP:   strb_d = '0;
      `DGA_COMM_MREQ:  strb_d[S_MREQ]  = 1'b1;
      `DGA_COMM_IORQ:  strb_d[S_IORQ]  = 1'b1;
      `DGA_COMM_FETCH: strb_d[S_FETCH] = 1'b1;
      `DGA_COMM_WRITE: strb_d[S_WRITE] = 1'b1;
      `DGA_COMM_LDPAN: strb_d[S_LDPAN] = 1'b1;
      // unused codes do nothing
      default:         strb_d = '0;
    endcase
  end

  // ********************************************************
  // strobe register
  // ********************************************************

  // one strobe per cycle the code is held
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      strb_q <= '0;
    end else if (clear) begin
      strb_q <= '0;
    end else begin
      strb_q <= strb_d;
    end
  end

  // also masks the first cycle after clear rises
  assign strb = clear ? '0 : strb_q;

  // bus polarities
  assign mreq_n = !strb[S_MREQ];
  assign iorq_n = !strb[S_IORQ];
  assign fetch  = strb[S_FETCH];
  assign write  = strb[S_WRITE];
  assign ldpan  = strb[S_LDPAN];

  // a single command drives a single strobe
  a_one_strobe : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({!mreq_n, !iorq_n, fetch, write, ldpan}));

endmodule

`default_nettype wire

// ==== decode_dga.sv ====
/* Top level of the decode gate array. Wires the power controller, IDB selector,
   command decoder and panel FIFO together and gates the panel address port.
*/
`timescale 1ns/10ps
`default_nettype none
`include "dga_consts.svh"

module decode_dga import dga_pkg::*; (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        pow_sense,
  input  wire cs_idbs_t    cs_idbs,
  input  wire cs_comm_t    cs_comm,
  input  wire logic        rmm_n,
  input  wire idb_byte_t   idb_in,
  output idb_byte_t        pan_addr,
  output idb_nibble_t      idb_out,
  output logic             epan_n,
  output logic             ecsr_n,
  output logic             edo_n,
  output logic             eior_n,
  output logic             mreq_n,
  output logic             iorq_n,
  output logic             fetch,
  output logic             write,
  output logic             fifo_full_n,
  output logic             fifo_empty_n,
  output logic             cl_n,
  output logic             pfail_n
);

  logic      clear;
  logic      ldpan;
  logic      fifo_full;
  logic      fifo_empty;
  idb_byte_t fifo_head;

  idb_bus_if idb_bus ();

  // external pins onto the shared idb path
  assign idb_bus.idb_in = idb_in;
  assign epan_n         = idb_bus.epan_n;

  power_ctl u_pow (
    .clk       (clk),
    .rst_n     (rst_n),
    .pow_sense (pow_sense),
    .clear     (clear),
    .pfail_n   (pfail_n),
    .bus       (idb_bus.pow)
  );

  idb_select u_idbs (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (clear),
    .cs_idbs (cs_idbs),
    .ecsr_n  (ecsr_n),
    .edo_n   (edo_n),
    .eior_n  (eior_n),
    .bus     (idb_bus.sel)
  );

  comm_decode u_comm (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (clear),
    .cs_comm (cs_comm),
    .mreq_n  (mreq_n),
    .iorq_n  (iorq_n),
    .fetch   (fetch),
    .write   (write),
    .ldpan   (ldpan)
  );

  // ldpan pushes, rmm_n low pops every edge
  panel_fifo #(
    .DEPTH (`DGA_FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .clear    (clear),
    .wr       (ldpan),
    .rd       (!rmm_n),
    .bus      (idb_bus.fifo),
    .data_out (fifo_head),
    .full     (fifo_full),
    .empty    (fifo_empty)
  );

  // panel address port only driven while the panel reads
  assign pan_addr = rmm_n ? '0 : fifo_head;

  // status goes out on the low pins when the panel source is on
  assign idb_out = idb_bus.epan_n ? idb_in[3:0] : idb_bus.status;

  assign fifo_full_n  = !fifo_full;
  assign fifo_empty_n = !fifo_empty;
  assign cl_n         = !clear;

endmodule

`default_nettype wire

// ==== tb_decode_dga.sv ====
/* Directed testbench for the decode gate array top level. Walks power-up, source
   select, command strobes, panel FIFO fill and drain, status merge and power fail.
*/
`timescale 1ns/10ps
`default_nettype none
`include "dga_consts.svh"

module tb_decode_dga import dga_pkg::*; ();

  // run limit, about ten times the directed sequence
  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  logic        pow_sense;
  cs_idbs_t    cs_idbs;
  cs_comm_t    cs_comm;
  logic        rmm_n;
  idb_byte_t   idb_in;
  idb_byte_t   pan_addr;
  idb_nibble_t idb_out;
  logic        epan_n;
  logic        ecsr_n;
  logic        edo_n;
  logic        eior_n;
  logic        mreq_n;
  logic        iorq_n;
  logic        fetch;
  logic        write;
  logic        fifo_full_n;
  logic        fifo_empty_n;
  logic        cl_n;
  logic        pfail_n;

  // bytes the fifo should hold, oldest first
  idb_byte_t exp_q [$];
  int        cycles = 0;

  decode_dga uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .pow_sense    (pow_sense),
    .cs_idbs      (cs_idbs),
    .cs_comm      (cs_comm),
    .rmm_n        (rmm_n),
    .idb_in       (idb_in),
    .pan_addr     (pan_addr),
    .idb_out      (idb_out),
    .epan_n       (epan_n),
    .ecsr_n       (ecsr_n),
    .edo_n        (edo_n),
    .eior_n       (eior_n),
    .mreq_n       (mreq_n),
    .iorq_n       (iorq_n),
    .fetch        (fetch),
    .write        (write),
    .fifo_full_n  (fifo_full_n),
    .fifo_empty_n (fifo_empty_n),
    .cl_n         (cl_n),
    .pfail_n      (pfail_n)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ************************************************************
  // error reporting and compare tasks
  // ************************************************************

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_byte(input string name, input idb_byte_t got, input idb_byte_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_nibble(input string name, input idb_nibble_t got,
                              input idb_nibble_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // hung run guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error($sformatf("timeout, tests still running after %0d cycles", MAX_CYCLES));
    end
  end

  // ************************************************************
  // expected-value helpers
  // ************************************************************

  // one-hot-low enable per select code, status on the pins for the panel code
  task automatic check_enables(input cs_idbs_t code);
    check_bit("epan_n", epan_n, code != `DGA_IDBS_PANEL);
    check_bit("ecsr_n", ecsr_n, code != `DGA_IDBS_CSR);
    check_bit("edo_n", edo_n, code != `DGA_IDBS_DOUT);
    check_bit("eior_n", eior_n, code != `DGA_IDBS_IOR);
    if (code == `DGA_IDBS_PANEL) begin
      check_nibble("idb_out", idb_out, 4'h1);
    end else begin
      check_nibble("idb_out", idb_out, idb_in[3:0]);
    end
  endtask

  task automatic check_strobes(input cs_comm_t code);
    check_bit("mreq_n", mreq_n, code != `DGA_COMM_MREQ);
    check_bit("iorq_n", iorq_n, code != `DGA_COMM_IORQ);
    check_bit("fetch", fetch, code == `DGA_COMM_FETCH);
    check_bit("write", write, code == `DGA_COMM_WRITE);
  endtask

  task automatic check_idle();
    check_bit("epan_n", epan_n, 1'b1);
    check_bit("ecsr_n", ecsr_n, 1'b1);
    check_bit("edo_n", edo_n, 1'b1);
    check_bit("eior_n", eior_n, 1'b1);
    check_strobes(`DGA_COMM_NOP);
  endtask

  // edge 1 registers ldpan, edge 2 captures idb_in
  task automatic load_byte(input idb_byte_t b, input idb_byte_t stored);
    @(posedge clk);
    cs_comm <= `DGA_COMM_LDPAN;
    @(posedge clk);
    cs_comm <= `DGA_COMM_NOP;
    idb_in  <= b;
    @(posedge clk);
    // write while full is lost
    if (exp_q.size() < `DGA_FIFO_DEPTH) begin
      exp_q.push_back(stored);
    end
    @(negedge clk);
    check_bit("fifo_full_n", fifo_full_n, exp_q.size() != `DGA_FIFO_DEPTH);
    check_bit("fifo_empty_n", fifo_empty_n, exp_q.size() != 0);
  endtask

  // rmm_n low pops one byte per edge, head shown on pan_addr
  task automatic drain_fifo();
    idb_byte_t head;
    if (exp_q.size() > 0) begin
      @(posedge clk);
      rmm_n <= 1'b0;
      while (exp_q.size() > 0) begin
        @(negedge clk);
        head = exp_q.pop_front();
        check_byte("pan_addr", pan_addr, head);
        @(posedge clk);
        if (exp_q.size() == 0) begin
          rmm_n <= 1'b1;
        end
      end
      @(negedge clk);
      check_bit("fifo_empty_n", fifo_empty_n, 1'b0);
      check_byte("pan_addr", pan_addr, 8'h00);
    end
  endtask

  // ************************************************************
  // directed tests
  // ************************************************************

  // panel code and ldpan offered under clear, nothing may react
  task automatic after_reset();
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_PANEL;
    cs_comm <= `DGA_COMM_LDPAN;
    idb_in  <= 8'h5a;
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_bit("cl_n", cl_n, 1'b0);
    check_bit("pfail_n", pfail_n, 1'b1);
    check_idle();
    check_bit("fifo_empty_n", fifo_empty_n, 1'b0);
    check_bit("fifo_full_n", fifo_full_n, 1'b1);
    check_byte("pan_addr", pan_addr, 8'h00);
    // panel enable held off by clear, so the pins pass idb_in
    check_nibble("idb_out", idb_out, 4'ha);
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_NONE;
    cs_comm <= `DGA_COMM_NOP;
  endtask

  task automatic power_up_sequence();
    int edge_n;
    @(posedge clk);
    pow_sense <= 1'b1;
    // edge 1 samples sense high, clear drops SETTLE+1 edges after it
    for (edge_n = 1; edge_n <= `DGA_POW_SETTLE + 2; edge_n++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("cl_n", cl_n, edge_n == `DGA_POW_SETTLE + 2);
    end
    check_bit("pfail_n", pfail_n, 1'b1);
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_PANEL;
    idb_in  <= 8'hc3;
    @(posedge clk);
    @(negedge clk);
    check_bit("epan_n", epan_n, 1'b0);
    check_nibble("idb_out", idb_out, 4'h1);
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_NONE;
  endtask

  task automatic select_decode();
    cs_idbs_t codes [8] = '{`DGA_IDBS_NONE, `DGA_IDBS_PANEL, `DGA_IDBS_CSR,
                            `DGA_IDBS_DOUT, `DGA_IDBS_IOR, 5'd5, 5'd12, 5'd31};
    cs_idbs_t prev;
    int       k;
    prev = `DGA_IDBS_NONE;
    for (k = 0; k < 8; k++) begin
      @(posedge clk);
      cs_idbs <= codes[k];
      // old code still decoded until the next edge
      @(negedge clk);
      check_enables(prev);
      @(posedge clk);
      @(negedge clk);
      check_enables(codes[k]);
      prev = codes[k];
    end
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_NONE;
  endtask

  task automatic command_strobes();
    cs_comm_t codes [7] = '{`DGA_COMM_NOP, `DGA_COMM_MREQ, `DGA_COMM_IORQ,
                            `DGA_COMM_FETCH, `DGA_COMM_WRITE, 5'd6, 5'd17};
    int       k;
    for (k = 0; k < 7; k++) begin
      @(posedge clk);
      cs_comm <= codes[k];
      @(posedge clk);
      cs_comm <= `DGA_COMM_NOP;
      @(negedge clk);
      check_strobes(codes[k]);
      @(posedge clk);
      @(negedge clk);
      check_strobes(`DGA_COMM_NOP);
    end
    // held three cycles, strobe for three cycles
    @(posedge clk);
    cs_comm <= `DGA_COMM_FETCH;
    for (k = 0; k < 3; k++) begin
      @(posedge clk);
      if (k == 2) begin
        cs_comm <= `DGA_COMM_NOP;
      end
      @(negedge clk);
      check_strobes(`DGA_COMM_FETCH);
    end
    @(posedge clk);
    @(negedge clk);
    check_strobes(`DGA_COMM_NOP);
    check_bit("fifo_empty_n", fifo_empty_n, 1'b0);
  endtask

  // one byte past full, the last one must be dropped
  task automatic fifo_fill_and_drain();
    idb_byte_t b;
    int        n;
    for (n = 0; n < `DGA_FIFO_DEPTH + 1; n++) begin
      b = idb_byte_t'($urandom);
      load_byte(b, b);
    end
    check_bit("fifo_full_n", fifo_full_n, 1'b0);
    // port dark while the panel is not reading
    check_byte("pan_addr", pan_addr, 8'h00);
    drain_fifo();
  endtask

  task automatic panel_status_merge();
    idb_byte_t b;
    idb_byte_t c;
    b = idb_byte_t'($urandom);
    c = idb_byte_t'($urandom);
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_PANEL;
    // high nibble from the pins, low nibble is power good status
    load_byte(b, {b[7:4], 4'h1});
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_NONE;
    load_byte(c, c);
    drain_fifo();
  endtask

  task automatic power_fail_sequence();
    idb_byte_t b;
    int        edge_n;
    b = idb_byte_t'($urandom);
    load_byte(b, b);
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_PANEL;
    @(posedge clk);
    pow_sense <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_bit("pfail_n", pfail_n, 1'b0);
    check_bit("cl_n", cl_n, 1'b1);
    check_bit("epan_n", epan_n, 1'b0);
    check_nibble("idb_out", idb_out, 4'h2);
    // warning window, then clear returns
    for (edge_n = 1; edge_n <= `DGA_POW_HOLD; edge_n++) begin
      @(posedge clk);
      @(negedge clk);
      check_bit("cl_n", cl_n, edge_n != `DGA_POW_HOLD);
      check_bit("pfail_n", pfail_n, edge_n == `DGA_POW_HOLD);
    end
    // fifo empties on the first edge that sees clear
    @(posedge clk);
    @(negedge clk);
    check_bit("fifo_empty_n", fifo_empty_n, 1'b0);
    check_bit("epan_n", epan_n, 1'b1);
    check_nibble("idb_out", idb_out, idb_in[3:0]);
    exp_q.delete();
    @(posedge clk);
    cs_idbs <= `DGA_IDBS_NONE;
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    void'($urandom(32'ha437));
    rst_n     = 1'b0;
    pow_sense = 1'b0;
    cs_idbs   = `DGA_IDBS_NONE;
    cs_comm   = `DGA_COMM_NOP;
    rmm_n     = 1'b1;
    idb_in    = 8'h00;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    after_reset();
    power_up_sequence();
    select_decode();
    command_strobes();
    fifo_fill_and_drain();
    panel_status_merge();
    power_fail_sequence();

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+.
dga_pkg.sv
idb_bus_if.sv
panel_fifo.sv
power_ctl.sv
idb_select.sv
comm_decode.sv
decode_dga.sv
tb_decode_dga.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the decode gate array testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_decode_dga \
  -f files.f -o tb_decode_dga
./obj_dir/tb_decode_dga
